//--- flist.f
rtl/aud_dsp_pkg.sv
rtl/dsp_ctrl.sv
rtl/lrck_frame_timer.sv
rtl/sram_addr_gen.sv
rtl/interp_unit.sv
rtl/aud_dsp.sv
tb/tb_clkgen.sv
tb/aud_dsp_chk.sv
tb/tb_aud_dsp.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_aud_dsp \
    -f flist.f --Mdir obj_dir -o tb_aud_dsp > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_aud_dsp > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

//--- tb/tb_aud_dsp.sv
`timescale 1ns/1ns

module tb_aud_dsp;
    import aud_dsp_pkg::*;

    typedef struct packed {
        speed_t     speed;
        logic       interp;
        addr_t      end_addr;
        logic       stall;      // player ready drawn at random
        logic [7:0] pause_at;   // pause and resume after this many samples, 0 none
        logic [7:0] stop_at;    // stop and restart after this many samples, 0 none
        logic [3:0] step;       // expected address step
        logic [1:0] slog;       // expected log2 of the slow factor
        logic [9:0] count;      // expected number of samples taken
    } row_t;

    localparam int NROWS = 9;

    logic    clk, rst_n;
    logic    start, pause, stop, interp, daclrck, player_ready;
    speed_t  speed;
    addr_t   end_addr, sram_addr;
    sample_t sram_data, sample;
    logic    sample_valid;
    bit      stall_on;
    integer  seed;
    int      errors, fails;
    row_t    tbl [NROWS];
    sample_t got [$];
    sample_t exp_q [$];

    tb_clkgen u_clkgen (.o_clk(clk), .o_rst_n(rst_n));

    aud_dsp UUT (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_start        (start),
        .i_pause        (pause),
        .i_stop         (stop),
        .i_speed        (speed),
        .i_interp       (interp),
        .i_end_addr     (end_addr),
        .i_daclrck      (daclrck),
        .i_sram_data    (sram_data),
        .i_player_ready (player_ready),
        .o_sram_addr    (sram_addr),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    // sram contents, address times 0x0101 cut to 16 bits
    function automatic sample_t word_at(int a);
        logic [31:0] p;
        p = a * 32'h101;
        return sample_t'(p[15:0]);
    endfunction

    assign sram_data = word_at(int'(sram_addr));

    always begin
        repeat (16) @(posedge clk);
        #2 daclrck = ~daclrck;   // one falling edge every 32 cycles
    end

    always @(posedge clk) begin
        #2;
        player_ready = stall_on ? (($random(seed) & 15) == 0) : 1'b1;
    end

    // transfer happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n && sample_valid && player_ready) got.push_back(sample);
    end

    task automatic pulse_ctrl(input logic st, input logic pa, input logic sp);
        @(posedge clk);
        #2 {start, pause, stop} = {st, pa, sp};
        @(posedge clk);
        #2 {start, pause, stop} = 3'b000;
    endtask

    task automatic build_expected(input row_t r);
        int n;
        int a;
        int k;
        int mixv;
        n = 1 << r.slog;
        exp_q.delete();
        for (a = 0; a <= int'(r.end_addr); a += int'(r.step)) begin
            exp_q.push_back(word_at(a));
            for (k = 1; k < n; k++) begin
                if (!r.interp) begin
                    exp_q.push_back(word_at(a));   // zero-order hold
                end else if (a < int'(r.end_addr)) begin
                    mixv = int'(word_at(a + 1)) * k + int'(word_at(a)) * (n - k);
                    exp_q.push_back(sample_t'(mixv >>> r.slog));
                end
            end
        end
    endtask

    task automatic wait_samples(input int n, output bit ok);
        int cyc;
        cyc = 0;
        while (got.size() < n && cyc < 150 * n + 2000) begin
            @(posedge clk);
            cyc++;
        end
        ok = (got.size() >= n);
        if (!ok) begin
            $display("timeout waiting for sample %0d, only %0d arrived", n, got.size());
            errors++;
        end
    endtask

    task automatic expect_quiet(input int cycles, input bit want_idle, input string what);
        int n0;
        n0 = got.size();
        repeat (cycles) @(posedge clk);
        if (got.size() != n0) begin
            $display("samples still arriving after %s", what);
            errors++;
        end
        if (want_idle && UUT.u_ctrl.state_q != S_IDLE) begin
            $display("state machine not back in idle after %s", what);
            errors++;
        end
    endtask

    task automatic run_row(input int idx, input row_t r);
        int      err0;
        int      i;
        bit      ok;
        sample_t full [$];
        err0 = errors;
        stall_on = 1'b0;
        pulse_ctrl(1'b0, 1'b0, 1'b1);   // leaves any earlier playback
        repeat (4) @(posedge clk);
        got.delete();
        build_expected(r);
        if (r.stop_at != 0) begin
            full = exp_q;
            for (i = int'(r.stop_at) - 1; i >= 0; i--)
                exp_q.push_front(full[i]);
        end
        stall_on = r.stall;
        @(posedge clk);
        #2;
        speed    = r.speed;
        interp   = r.interp;
        end_addr = r.end_addr;
        pulse_ctrl(1'b1, 1'b0, 1'b0);
        ok = 1'b1;
        if (r.pause_at != 0) begin
            wait_samples(int'(r.pause_at), ok);
            if (ok) begin
                pulse_ctrl(1'b0, 1'b1, 1'b0);
                expect_quiet(128, 1'b0, "pause");
                pulse_ctrl(1'b1, 1'b0, 1'b0);   // resume
            end
        end
        if (ok && r.stop_at != 0) begin
            wait_samples(int'(r.stop_at), ok);
            if (ok) begin
                pulse_ctrl(1'b0, 1'b0, 1'b1);
                expect_quiet(128, 1'b1, "stop");
                pulse_ctrl(1'b1, 1'b0, 1'b0);   // restart from address 0
            end
        end
        if (ok) wait_samples(int'(r.count), ok);
        if (ok) expect_quiet(96, 1'b1, "end of playback");
        if (got.size() != int'(r.count)) begin
            $display("** Error: sample count 0x%0h, expected 0x%0h", got.size(), r.count);
            errors++;
        end
        for (i = 0; i < got.size() && i < exp_q.size(); i++) begin
            if (got[i] !== exp_q[i]) begin
                $display("** Error: o_sample[%0d] = 0x%h, expected 0x%h", i, got[i], exp_q[i]);
                errors++;
            end
        end
        if (errors != err0) fails++;
        $display("test %0d speed 0x%h interp %0d end 0x%h: %0d samples, %s", idx, r.speed,
                 r.interp, r.end_addr, got.size(), (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        int i;
        int cyc;
        seed = 52;
        {start, pause, stop, interp, daclrck, player_ready} = 6'b0;
        speed    = SPEED_X1;
        end_addr = '0;
        stall_on = 1'b0;
        errors   = 0;
        fails    = 0;
        // speed, interp, end, stall, pause_at, stop_at, step, slog, count
        tbl[0] = '{SPEED_X1, 1'b0, 20'd20, 1'b0, 8'd0, 8'd0, 4'd1, 2'd0, 10'd21};
        tbl[1] = '{8'h20, 1'b0, 20'd20, 1'b0, 8'd0, 8'd0, 4'd4, 2'd0, 10'd6};
        tbl[2] = '{SLOW_QUARTER, 1'b0, 20'd5, 1'b0, 8'd0, 8'd0, 4'd1, 2'd2, 10'd24};
        tbl[3] = '{SLOW_HALF, 1'b1, 20'd130, 1'b0, 8'd0, 8'd0, 4'd1, 2'd1, 10'd261};
        tbl[4] = '{SLOW_EIGHTH, 1'b1, 20'd3, 1'b0, 8'd0, 8'd0, 4'd1, 2'd3, 10'd25};
        tbl[5] = '{SPEED_X1, 1'b0, 20'd20, 1'b1, 8'd0, 8'd0, 4'd1, 2'd0, 10'd21};
        tbl[6] = '{SPEED_X8, 1'b0, 20'd144, 1'b1, 8'd0, 8'd0, 4'd8, 2'd0, 10'd19};
        tbl[7] = '{SPEED_X1, 1'b0, 20'd30, 1'b0, 8'd5, 8'd9, 4'd1, 2'd0, 10'd40};
        tbl[8] = '{8'h05, 1'b0, 20'd10, 1'b0, 8'd0, 8'd0, 4'd1, 2'd0, 10'd11};
        cyc = 0;
        while (!rst_n && cyc < 100) begin
            @(posedge clk);
            cyc++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            errors++;
        end else begin
            for (i = 0; i < NROWS; i++)
                run_row(i, tbl[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", NROWS, fails, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- tb/aud_dsp_chk.sv
`timescale 1ns/1ns

module aud_dsp_chk (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input logic                 i_playing,
    input logic                 i_player_ready,
    input logic                 i_sample_valid,
    input aud_dsp_pkg::sample_t i_sample,
    input aud_dsp_pkg::addr_t   i_sram_addr,
    input aud_dsp_pkg::addr_t   i_end_addr
);

    // a waiting sample stays put until the player takes it
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sample_valid && !i_player_ready |=> i_sample_valid && $stable(i_sample))
        else $error("sample dropped or changed while waiting for ready");

    a_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_playing |-> i_sram_addr <= i_end_addr)
        else $error("sram address beyond end address");

    a_rst: assert property (@(posedge i_clk) !i_rst_n |-> !i_sample_valid)
        else $error("sample valid during reset");

endmodule

bind aud_dsp aud_dsp_chk u_chk (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_playing      (playing),
    .i_player_ready (i_player_ready),
    .i_sample_valid (o_sample_valid),
    .i_sample       (o_sample),
    .i_sram_addr    (o_sram_addr),
    .i_end_addr     (i_end_addr)
);

//--- tb/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic o_clk,
    output logic o_rst_n
);
    always begin
        o_clk = 1'b0;
        #10;
        o_clk = 1'b1;
        #10;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (16) @(posedge o_clk);
        #2 o_rst_n = 1'b1;   // release just after an edge
    end

endmodule

//--- rtl/aud_dsp.sv
`timescale 1ns/1ns

module aud_dsp (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_pause,
    input  logic                 i_stop,
    input  aud_dsp_pkg::speed_t  i_speed,
    input  logic                 i_interp,     // 0 hold, 1 linear
    input  aud_dsp_pkg::addr_t   i_end_addr,
    input  logic                 i_daclrck,
    input  aud_dsp_pkg::sample_t i_sram_data,
    input  logic                 i_player_ready,
    output aud_dsp_pkg::addr_t   o_sram_addr,
    output aud_dsp_pkg::sample_t o_sample,
    output logic                 o_sample_valid
);
    import aud_dsp_pkg::*;

    logic       playing;
    logic       rewind;
    step_t      step;
    slow_log2_t slow_log2;
    logic       frame;
    phase_t     phase;
    logic       advance;
    logic       last;
    logic       slot_free;

    dsp_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .i_speed     (i_speed),
        .i_last      (last),
        .i_frame     (frame),
        .o_playing   (playing),
        .o_rewind    (rewind),
        .o_step      (step),
        .o_slow_log2 (slow_log2)
    );

    lrck_frame_timer u_timer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_daclrck   (i_daclrck),
        .i_playing   (playing),
        .i_rewind    (rewind),
        .i_slot_free (slot_free),
        .i_slow_log2 (slow_log2),
        .i_interp    (i_interp),
        .o_frame     (frame),
        .o_phase     (phase),
        .o_advance   (advance)
    );

    sram_addr_gen u_addr (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rewind    (rewind),
        .i_frame     (frame),
        .i_advance   (advance),
        .i_step      (step),
        .i_end_addr  (i_end_addr),
        .o_sram_addr (o_sram_addr),
        .o_last      (last)
    );

    interp_unit u_interp (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_frame        (frame),
        .i_phase        (phase),
        .i_slow_log2    (slow_log2),
        .i_interp       (i_interp),
        .i_sram_data    (i_sram_data),
        .i_player_ready (i_player_ready),
        .o_sample       (o_sample),
        .o_sample_valid (o_sample_valid),
        .o_slot_free    (slot_free)
    );

endmodule

//--- rtl/interp_unit.sv
`timescale 1ns/1ns

module interp_unit (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_frame,
    input  aud_dsp_pkg::phase_t     i_phase,
    input  aud_dsp_pkg::slow_log2_t i_slow_log2,
    input  logic                    i_interp,
    input  aud_dsp_pkg::sample_t    i_sram_data,
    input  logic                    i_player_ready,
    output aud_dsp_pkg::sample_t    o_sample,
    output logic                    o_sample_valid,
    output logic                    o_slot_free
);
    import aud_dsp_pkg::*;

    sample_t                    sample_q;
    sample_t                    sample_d;
    sample_t                    old_q;      // word from before the last advance
    logic                       valid_q;
    logic [3:0]                 w_old;      // N - k
    logic signed [SAMPLE_W+4:0] mix;
    logic signed [SAMPLE_W+4:0] mix_sh;

    assign w_old = (4'd1 << i_slow_log2) - {1'b0, i_phase};

    // new*k + old*(N-k), exact divide by N as a shift
    assign mix    = i_sram_data * $signed({2'b00, i_phase})
                  + old_q * $signed({1'b0, w_old});
    assign mix_sh = mix >>> i_slow_log2;

    always_comb begin
        if (!i_interp || (i_slow_log2 == 2'd0) || (i_phase == 3'd0)) begin
            sample_d = i_sram_data;
        end else begin
            sample_d = mix_sh[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_frame) begin
            sample_q <= sample_d;
            if (i_phase == 3'd0) begin
                old_q <= i_sram_data;
            end
        end
    end

    // output register, valid holds until the player takes it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_frame) begin
            valid_q <= 1'b1;
        end else if (i_player_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign o_slot_free    = ~valid_q | i_player_ready;
    assign o_sample       = sample_q;
    assign o_sample_valid = valid_q;

endmodule

//--- rtl/sram_addr_gen.sv
`timescale 1ns/1ns

module sram_addr_gen (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_rewind,
    input  logic                i_frame,
    input  logic                i_advance,
    input  aud_dsp_pkg::step_t  i_step,
    input  aud_dsp_pkg::addr_t  i_end_addr,
    output aud_dsp_pkg::addr_t  o_sram_addr,
    output logic                o_last
);
    import aud_dsp_pkg::*;

    addr_t           addr_q;
    logic [ADDR_W:0] next_sum;   // one extra bit so the top end cannot wrap
    logic            exceed;

    assign next_sum = {1'b0, addr_q} + {{(ADDR_W-3){1'b0}}, i_step};
    assign exceed   = next_sum > {1'b0, i_end_addr};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (i_rewind) begin
            addr_q <= '0;
        end else if (i_frame && i_advance && !exceed) begin
            addr_q <= next_sum[ADDR_W-1:0];
        end
    end

    // address holds on the final step, ctrl sees this and ends playback
    assign o_last      = i_advance & exceed;
    assign o_sram_addr = addr_q;

endmodule

//--- rtl/lrck_frame_timer.sv
`timescale 1ns/1ns

module lrck_frame_timer (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_daclrck,
    input  logic                    i_playing,
    input  logic                    i_rewind,
    input  logic                    i_slot_free,
    input  aud_dsp_pkg::slow_log2_t i_slow_log2,
    input  logic                    i_interp,
    output logic                    o_frame,
    output aud_dsp_pkg::phase_t     o_phase,
    output logic                    o_advance
);
    import aud_dsp_pkg::*;

    logic [1:0] lrck_sync;   // two-flop synchronizer
    logic       lrck_prev;
    logic       fall_q;
    phase_t     phase_q;
    phase_t     last_phase;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrck_sync <= 2'b00;
            lrck_prev <= 1'b0;
            fall_q    <= 1'b0;
        end else begin
            lrck_sync <= {lrck_sync[0], i_daclrck};
            lrck_prev <= lrck_sync[1];
            fall_q    <= lrck_prev & ~lrck_sync[1];
        end
    end

    // a fall seen while paused, idle or with a sample still waiting is dropped
    assign o_frame = fall_q & i_playing & i_slot_free;

    assign last_phase = phase_t'((4'd1 << i_slow_log2) - 4'd1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_q <= '0;
        end else if (i_rewind) begin
            phase_q <= '0;
        end else if (o_frame) begin
            if (phase_q >= last_phase) begin
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + 3'd1;
            end
        end
    end

    always_comb begin
        if (i_slow_log2 == 2'd0) begin
            o_advance = 1'b1;
        end else if (i_interp) begin
            o_advance = (phase_q == 3'd0);   // step early, then blend toward new word
        end else begin
            o_advance = (phase_q >= last_phase);
        end
    end

    assign o_phase = phase_q;

endmodule

//--- rtl/dsp_ctrl.sv
`timescale 1ns/1ns

module dsp_ctrl (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  logic                    i_pause,
    input  logic                    i_stop,
    input  aud_dsp_pkg::speed_t     i_speed,
    input  logic                    i_last,
    input  logic                    i_frame,
    output logic                    o_playing,
    output logic                    o_rewind,
    output aud_dsp_pkg::step_t      o_step,
    output aud_dsp_pkg::slow_log2_t o_slow_log2
);
    import aud_dsp_pkg::*;

    state_t     state_q, state_d;
    step_t      step_d, step_q;
    slow_log2_t shift_d, shift_q;
    logic       fast_ok;

    // fast codes are whole multiples of the x1 code, up to x8
    assign fast_ok = (i_speed[2:0] == 3'd0) && (i_speed >= SPEED_X1) && (i_speed <= SPEED_X8);

    always_comb begin
        step_d  = 4'd1;     // anything unsupported plays at x1
        shift_d = 2'd0;
        case (i_speed)
            SLOW_HALF:    shift_d = 2'd1;
            SLOW_QUARTER: shift_d = 2'd2;
            SLOW_EIGHTH:  shift_d = 2'd3;
            default: begin
                if (fast_ok) begin
                    step_d = i_speed[6:3];
                end
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_start) state_d = S_PLAY;
            end
            S_PLAY: begin
                if (i_stop) begin
                    state_d = S_STOP;
                end else if (i_frame && i_last) begin
                    state_d = S_IDLE;   // last sample already sent on this frame
                end else if (i_pause) begin
                    state_d = S_PAUSE;
                end
            end
            S_PAUSE: begin
                if (i_stop) begin
                    state_d = S_STOP;
                end else if (i_start) begin
                    state_d = S_PLAY;   // resume where we left off
                end
            end
            default: state_d = S_IDLE;  // stop lasts one cycle
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            step_q  <= 4'd1;
            shift_q <= 2'd0;
        end else begin
            state_q <= state_d;
            step_q  <= step_d;
            shift_q <= shift_d;
        end
    end

    assign o_playing   = (state_q == S_PLAY);
    assign o_rewind    = (state_q == S_IDLE) && i_start;
    assign o_step      = step_q;
    assign o_slow_log2 = shift_q;

endmodule

//--- rtl/aud_dsp_pkg.sv
package aud_dsp_pkg;

    // sram and sample widths
    localparam int ADDR_W   = 20;
    localparam int SAMPLE_W = 16;
    localparam int SPEED_W  = 8;

    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [SPEED_W-1:0]         speed_t;

    typedef logic [3:0] step_t;       // address step per frame, 1..8
    typedef logic [1:0] slow_log2_t;  // slow factor N = 2**s
    typedef logic [2:0] phase_t;      // 0 .. N-1

    // fast codes carry the multiplier in bits [6:3]
    localparam speed_t SPEED_X1 = 8'h08;
    localparam speed_t SPEED_X8 = 8'h40;

    // slow codes, bits [6:3] zero
    localparam speed_t SLOW_HALF    = 8'h01;
    localparam speed_t SLOW_QUARTER = 8'h03;
    localparam speed_t SLOW_EIGHTH  = 8'h07;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_PLAY  = 2'd1,
        S_PAUSE = 2'd2,
        S_STOP  = 2'd3
    } state_t;

endpackage
